// File: logic/du_regs_pkg.sv
/*
  Register map of the debug unit as seen from the host port.
  All registers sit in one internal bank, one word per address.
  Breakpoint registers come in CTRL/DATA pairs from 0x10 upwards.
*/
package du_regs_pkg;

  localparam int DBG_ADDR_SIZE   = 8;
  localparam int MAX_BREAKPOINTS = 8;

  //////////////////////////////
  // Register addresses
  //////////////////////////////
  typedef enum logic [DBG_ADDR_SIZE-1:0] {
    DBG_CTRL    = 8'h00,
    DBG_HIT     = 8'h01,
    DBG_IE      = 8'h02,
    DBG_CAUSE   = 8'h03,
    DBG_BPCTRL0 = 8'h10,
    DBG_BPDATA0 = 8'h11,
    DBG_BPCTRL1 = 8'h12,
    DBG_BPDATA1 = 8'h13,
    DBG_BPCTRL2 = 8'h14,
    DBG_BPDATA2 = 8'h15,
    DBG_BPCTRL3 = 8'h16,
    DBG_BPDATA3 = 8'h17,
    DBG_BPCTRL4 = 8'h18,
    DBG_BPDATA4 = 8'h19,
    DBG_BPCTRL5 = 8'h1a,
    DBG_BPDATA5 = 8'h1b,
    DBG_BPCTRL6 = 8'h1c,
    DBG_BPDATA6 = 8'h1d,
    DBG_BPCTRL7 = 8'h1e,
    DBG_BPDATA7 = 8'h1f
  } du_reg_e;

  // HIT holds step at bit 0 and branch at bit 1
  localparam int HIT_BP_LSB = 4;

  // BPCTRL bit 0 is the read-only implemented flag
  localparam int BPCTRL_ENA_BIT = 1;
  localparam int BPCTRL_CC_LSB  = 4;

endpackage

// File: logic/du_cpu_pkg.sv
/*
  Core-side encodings used by the debug unit.
  Only the major opcodes the breakpoint logic looks at are listed.
  Exception vector: traps in the low half, interrupts in the high half.
*/
package du_cpu_pkg;

  //////////////////////////////
  // Major opcodes, bits 6:0
  //////////////////////////////
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b00_000_11,
    OPC_STORE  = 7'b01_000_11,
    OPC_BRANCH = 7'b11_000_11
  } opcode_e;

  //////////////////////////////
  // Breakpoint conditions
  //////////////////////////////
  typedef enum logic [2:0] {
    BP_CC_FETCH    = 3'd0,
    BP_CC_LD_ADR   = 3'd1,
    BP_CC_ST_ADR   = 3'd2,
    BP_CC_LDST_ADR = 3'd3
  } bp_cc_e;

  localparam int EXC_WIDTH = 32;

endpackage

// File: logic/du_host_port.sv
/*
  Host side of the debug port. Any strobe is an access.
  Host holds the strobe until ack and then drops it for a cycle or more.
  Ack needs three edges with ex_stall_i low after the strobe is seen.
*/
module du_host_port #(
  parameter int XLEN = 32
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  dbg_strb_i,
  input  logic                                  dbg_we_i,
  input  logic                                  dbg_stall_i,
  input  logic                                  ex_stall_i,
  input  logic [du_regs_pkg::DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [XLEN-1:0]                       dbg_d_i,
  output logic                                  dbg_ack_o,
  output logic                                  du_stall_o,
  output logic                                  du_flush_o,
  output logic                                  du_latch_nxt_pc_o,
  output logic                                  reg_we_o,
  output du_regs_pkg::du_reg_e                  reg_addr_o,
  output logic [XLEN-1:0]                       reg_d_o
);
  import du_regs_pkg::*;

  logic       strb_dly;
  logic       stall_dly;
  logic       strb_first;
  logic [2:0] ack_chain;

  // First cycle of a strobe
  assign strb_first = dbg_strb_i & ~strb_dly;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      strb_dly  <= 1'b0;
      stall_dly <= 1'b0;
      reg_we_o  <= 1'b0;
    end
    else
    begin
      strb_dly  <= dbg_strb_i;
      stall_dly <= dbg_stall_i;
      reg_we_o  <= strb_first & dbg_we_i;
    end
  end

  // Address and data simply follow the port
  always_ff @(posedge clk_i)
  begin
    reg_addr_o <= du_reg_e'(dbg_addr_i);
    reg_d_o    <= dbg_d_i;
  end

  // Acknowledge shifts down from bit 2, frozen by ex_stall_i
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_chain <= 3'b000;
    else if (!ex_stall_i)
      ack_chain <= {3{dbg_strb_i & ~dbg_ack_o}} & {1'b1, ack_chain[2:1]};
  end

  assign dbg_ack_o = ack_chain[0];

  //////////////////////////////
  // Core stall sequencing
  //////////////////////////////
  assign du_stall_o        = dbg_stall_i;
  assign du_latch_nxt_pc_o = dbg_stall_i & ~stall_dly;  // entering debug
  assign du_flush_o        = ~dbg_stall_i & stall_dly;  // leaving debug

endmodule

// File: logic/du_bp_unit.sv
/*
  Address breakpoints, BREAKPOINTS of them (1 to MAX_BREAKPOINTS).
  Hits are combinational, the sticky flags live in the status block.
  Unimplemented breakpoint addresses read back as 0.
*/
module du_bp_unit #(
  parameter int XLEN        = 32,
  parameter int BREAKPOINTS = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_we_i,
  input  du_regs_pkg::du_reg_e reg_addr_i,
  input  logic [XLEN-1:0]      reg_d_i,
  input  logic [XLEN-1:0]      pd_pc_i,
  input  logic [XLEN-1:0]      mem_memadr_i,
  input  du_cpu_pkg::opcode_e  mem_opcode_i,
  input  logic                 mem_bubble_i,
  input  logic                 mem_exc_any_i,
  input  logic                 dmem_ack_i,
  input  logic                 bu_flush_i,
  input  logic                 st_flush_i,
  output logic [BREAKPOINTS-1:0] bp_hit_o,
  output logic [XLEN-1:0]      bp_rdata_o
);
  import du_regs_pkg::*;
  import du_cpu_pkg::*;

  logic                   mem_read;
  logic                   mem_write;
  logic [BREAKPOINTS-1:0] sel_ctrl;
  logic [BREAKPOINTS-1:0] sel_data;
  logic                   bp_ena  [BREAKPOINTS];
  bp_cc_e                 bp_cc   [BREAKPOINTS];
  logic [XLEN-1:0]        bp_data [BREAKPOINTS];

  // Valid memory access in the MEM stage
  assign mem_read  = ~mem_exc_any_i & ~mem_bubble_i & (mem_opcode_i == OPC_LOAD);
  assign mem_write = ~mem_exc_any_i & ~mem_bubble_i & (mem_opcode_i == OPC_STORE);

  //////////////////////////////
  // Decode and comparators
  //////////////////////////////
  for (genvar n = 0; n < BREAKPOINTS; n++)
  begin : g_bp
    localparam logic [DBG_ADDR_SIZE-1:0] CTRL_ADR = DBG_ADDR_SIZE'(DBG_BPCTRL0 + 2 * n);
    localparam logic [DBG_ADDR_SIZE-1:0] DATA_ADR = DBG_ADDR_SIZE'(DBG_BPDATA0 + 2 * n);

    logic adr_eq;
    logic hit;

    assign sel_ctrl[n] = (reg_addr_i == CTRL_ADR);
    assign sel_data[n] = (reg_addr_i == DATA_ADR);
    assign adr_eq      = (mem_memadr_i == bp_data[n]) & dmem_ack_i;

    always_comb
    begin
      hit = 1'b0;
      if (bp_ena[n])
        case (bp_cc[n])
          BP_CC_FETCH    : hit = (pd_pc_i == bp_data[n]) & ~bu_flush_i & ~st_flush_i;
          BP_CC_LD_ADR   : hit = adr_eq & mem_read;
          BP_CC_ST_ADR   : hit = adr_eq & mem_write;
          BP_CC_LDST_ADR : hit = adr_eq & (mem_read | mem_write);
          default        : hit = 1'b0;
        endcase
    end

    assign bp_hit_o[n] = hit;
  end

  // Host writes to BPCTRLn / BPDATAn
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int n = 0; n < BREAKPOINTS; n++)
      begin
        bp_ena[n]  <= 1'b0;
        bp_cc[n]   <= BP_CC_FETCH;
        bp_data[n] <= '0;
      end
    end
    else if (reg_we_i)
    begin
      for (int n = 0; n < BREAKPOINTS; n++)
      begin
        if (sel_ctrl[n])
        begin
          bp_ena[n] <= reg_d_i[BPCTRL_ENA_BIT];
          bp_cc[n]  <= bp_cc_e'(reg_d_i[BPCTRL_CC_LSB +: 3]);
        end
        if (sel_data[n])
          bp_data[n] <= reg_d_i;
      end
    end
  end

  // Read-back, zero when no breakpoint address matches
  always_comb
  begin
    bp_rdata_o = '0;
    for (int n = 0; n < BREAKPOINTS; n++)
    begin
      if (sel_ctrl[n])
      begin
        bp_rdata_o[0]                  = 1'b1;
        bp_rdata_o[BPCTRL_ENA_BIT]     = bp_ena[n];
        bp_rdata_o[BPCTRL_CC_LSB +: 3] = bp_cc[n];
      end
      if (sel_data[n])
        bp_rdata_o = bp_data[n];
    end
  end

endmodule

// File: logic/du_trap_capture.sv
/*
  CAUSE register. A host write beats everything else.
  Lowest set trap bit wins, interrupts only count with no trap pending.
  Interrupt causes carry the top bit set.
*/
module du_trap_capture #(
  parameter int XLEN = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             reg_we_i,
  input  du_regs_pkg::du_reg_e             reg_addr_i,
  input  logic [XLEN-1:0]                  reg_d_i,
  input  logic                             du_flush_i,
  input  logic [du_cpu_pkg::EXC_WIDTH-1:0] du_exceptions_i,
  output logic [XLEN-1:0]                  cause_o
);
  import du_regs_pkg::*;
  import du_cpu_pkg::*;

  localparam int HALF  = EXC_WIDTH / 2;
  localparam int IDX_W = $clog2(HALF);
  localparam logic [XLEN-1:0] IRQ_FLAG = {1'b1, {(XLEN - 1){1'b0}}};

  logic [HALF-1:0]  traps;
  logic [HALF-1:0]  irqs;
  logic [IDX_W-1:0] trap_idx;
  logic [IDX_W-1:0] irq_idx;

  // Index of the lowest set bit, 0 when none
  function automatic logic [IDX_W-1:0] lowest_set(input logic [HALF-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = HALF - 1; i >= 0; i--)
      if (vec[i])
        idx = IDX_W'(i);
    return idx;
  endfunction

  assign traps    = du_exceptions_i[HALF-1:0];
  assign irqs     = du_exceptions_i[EXC_WIDTH-1:HALF];
  assign trap_idx = lowest_set(traps);
  assign irq_idx  = lowest_set(irqs);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cause_o <= '0;
    else if (reg_we_i && reg_addr_i == DBG_CAUSE)
      cause_o <= reg_d_i;
    else if (du_flush_i && !(|du_exceptions_i))
      cause_o <= '0;
    else if (|traps)
      cause_o <= XLEN'(trap_idx);
    else if (|irqs)
      cause_o <= IRQ_FLAG | XLEN'(irq_idx);
  end

endmodule

// File: logic/du_status.sv
/*
  CTRL, HIT and IE registers, breakpoint output and read-back.
  Needs XLEN of 32 or more. HIT flags stay set until the host writes HIT.
  dbg_q_o carries the register last addressed, one cycle later.
*/
module du_status #(
  parameter int XLEN        = 32,
  parameter int BREAKPOINTS = 3
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             reg_we_i,
  input  du_regs_pkg::du_reg_e             reg_addr_i,
  input  logic [XLEN-1:0]                  reg_d_i,
  input  logic                             if_nxt_bubble_i,
  input  logic                             if_bubble_i,
  input  du_cpu_pkg::opcode_e              if_opcode_i,
  input  logic [BREAKPOINTS-1:0]           bp_hit_i,
  input  logic [XLEN-1:0]                  bp_rdata_i,
  input  logic [XLEN-1:0]                  cause_i,
  input  logic [du_cpu_pkg::EXC_WIDTH-1:0] du_exceptions_i,
  input  logic                             dbg_stall_i,
  input  logic                             du_flush_i,
  input  logic                             st_flush_i,
  input  logic                             ex_stall_i,
  output logic [XLEN-1:0]                  dbg_q_o,
  output logic                             dbg_bp_o,
  output logic                             du_stall_if_o,
  output logic [31:0]                      du_ie_o
);
  import du_regs_pkg::*;
  import du_cpu_pkg::*;

  logic [1:0]             ctrl;
  logic                   step_flag;
  logic                   branch_flag;
  logic [BREAKPOINTS-1:0] bp_flag;
  logic                   step_hit;
  logic                   branch_hit;
  logic                   any_flag;
  logic [XLEN-1:0]        hit_word;
  logic [XLEN-1:0]        rdata;

  // Bit 0 single step, bit 1 branch break
  assign step_hit   = ctrl[0] & ~if_nxt_bubble_i;
  assign branch_hit = ctrl[1] & ~if_bubble_i & (if_opcode_i == OPC_BRANCH);
  assign any_flag   = step_flag | branch_flag | (|bp_flag);

  //////////////////////////////
  // Host registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ctrl    <= 2'b00;
      du_ie_o <= '0;
    end
    else if (reg_we_i)
    begin
      if (reg_addr_i == DBG_CTRL)
        ctrl <= reg_d_i[1:0];
      if (reg_addr_i == DBG_IE)
        du_ie_o <= reg_d_i[31:0];
    end
  end

  // Sticky hits, a host write replaces them
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      step_flag   <= 1'b0;
      branch_flag <= 1'b0;
      bp_flag     <= '0;
    end
    else if (reg_we_i && reg_addr_i == DBG_HIT)
    begin
      step_flag   <= reg_d_i[0];
      branch_flag <= reg_d_i[1];
      bp_flag     <= reg_d_i[HIT_BP_LSB +: BREAKPOINTS];
    end
    else
    begin
      step_flag   <= step_flag | step_hit;
      branch_flag <= branch_flag | branch_hit;
      bp_flag     <= bp_flag | bp_hit_i;
    end
  end

  //////////////////////////////
  // Core and host outputs
  //////////////////////////////
  assign du_stall_if_o = dbg_stall_i | any_flag;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dbg_bp_o <= 1'b0;
    else
      dbg_bp_o <= ~ex_stall_i & ~du_flush_i & ~st_flush_i & ((|du_exceptions_i) | any_flag);
  end

  always_comb
  begin
    hit_word                            = '0;
    hit_word[0]                         = step_flag;
    hit_word[1]                         = branch_flag;
    hit_word[HIT_BP_LSB +: BREAKPOINTS] = bp_flag;
  end

  // Anything else comes from the breakpoint block, 0 if undefined
  always_comb
  begin
    case (reg_addr_i)
      DBG_CTRL  : rdata = XLEN'(ctrl);
      DBG_HIT   : rdata = hit_word;
      DBG_IE    : rdata = XLEN'(du_ie_o);
      DBG_CAUSE : rdata = cause_i;
      default   : rdata = bp_rdata_i;
    endcase
  end

  always_ff @(posedge clk_i)
    dbg_q_o <= rdata;

endmodule

// File: logic/riscv_du.sv
/*
  Debug unit for a small RISC-V core, reached through a strobe port.
  BREAKPOINTS ranges from 1 to 8, XLEN must be 32 or more.
  Only the internal register bank is reachable from the host.
*/
module riscv_du #(
  parameter int XLEN        = 32,
  parameter int BREAKPOINTS = 3
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Host debug port
  input  logic                                  dbg_stall_i,
  input  logic                                  dbg_strb_i,
  input  logic                                  dbg_we_i,
  input  logic [du_regs_pkg::DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  logic [XLEN-1:0]                       dbg_d_i,
  output logic [XLEN-1:0]                       dbg_q_o,
  output logic                                  dbg_ack_o,
  output logic                                  dbg_bp_o,

  // Core side
  output logic                                  du_stall_o,
  output logic                                  du_stall_if_o,
  output logic                                  du_latch_nxt_pc_o,
  output logic                                  du_flush_o,
  output logic [31:0]                           du_ie_o,
  input  logic [XLEN-1:0]                       pd_pc_i,
  input  logic                                  if_nxt_bubble_i,
  input  logic                                  if_bubble_i,
  input  du_cpu_pkg::opcode_e                   if_opcode_i,
  input  logic                                  bu_flush_i,
  input  logic                                  st_flush_i,
  input  logic [XLEN-1:0]                       mem_memadr_i,
  input  du_cpu_pkg::opcode_e                   mem_opcode_i,
  input  logic                                  mem_bubble_i,
  input  logic                                  mem_exc_any_i,
  input  logic                                  dmem_ack_i,
  input  logic                                  ex_stall_i,
  input  logic [du_cpu_pkg::EXC_WIDTH-1:0]      du_exceptions_i
);
  import du_regs_pkg::*;

  logic                   reg_we;
  du_reg_e                reg_addr;
  logic [XLEN-1:0]        reg_d;
  logic [BREAKPOINTS-1:0] bp_hit;
  logic [XLEN-1:0]        bp_rdata;
  logic [XLEN-1:0]        cause;

  du_host_port #(.XLEN(XLEN)) u_host_port (
    .clk_i, .rst_ni, .dbg_strb_i, .dbg_we_i, .dbg_stall_i, .ex_stall_i,
    .dbg_addr_i, .dbg_d_i, .dbg_ack_o, .du_stall_o, .du_flush_o, .du_latch_nxt_pc_o,
    .reg_we_o   (reg_we),
    .reg_addr_o (reg_addr),
    .reg_d_o    (reg_d)
  );

  du_bp_unit #(.XLEN(XLEN), .BREAKPOINTS(BREAKPOINTS)) u_bp_unit (
    .clk_i, .rst_ni, .pd_pc_i, .mem_memadr_i, .mem_opcode_i, .mem_bubble_i,
    .mem_exc_any_i, .dmem_ack_i, .bu_flush_i, .st_flush_i,
    .reg_we_i   (reg_we),
    .reg_addr_i (reg_addr),
    .reg_d_i    (reg_d),
    .bp_hit_o   (bp_hit),
    .bp_rdata_o (bp_rdata)
  );

  du_trap_capture #(.XLEN(XLEN)) u_trap_capture (
    .clk_i, .rst_ni, .du_exceptions_i,
    .reg_we_i   (reg_we),
    .reg_addr_i (reg_addr),
    .reg_d_i    (reg_d),
    .du_flush_i (du_flush_o),
    .cause_o    (cause)
  );

  du_status #(.XLEN(XLEN), .BREAKPOINTS(BREAKPOINTS)) u_status (
    .clk_i, .rst_ni, .if_nxt_bubble_i, .if_bubble_i, .if_opcode_i, .du_exceptions_i,
    .dbg_stall_i, .st_flush_i, .ex_stall_i, .dbg_q_o, .dbg_bp_o, .du_stall_if_o, .du_ie_o,
    .reg_we_i   (reg_we),
    .reg_addr_i (reg_addr),
    .reg_d_i    (reg_d),
    .bp_hit_i   (bp_hit),
    .bp_rdata_i (bp_rdata),
    .cause_i    (cause),
    .du_flush_i (du_flush_o)
  );

endmodule

// File: sim/tb_riscv_du.sv
/*
  Testbench for riscv_du with XLEN 32 and BREAKPOINTS 3.
  Table rows run in order, each one starts and ends on a falling edge.
  Core inputs go back to idle after every event row.
*/
module tb_riscv_du;
  import du_regs_pkg::*;
  import du_cpu_pkg::*;

  localparam int XLEN        = 32;
  localparam int BREAKPOINTS = 3;
  localparam int ACK_TIMEOUT = 20;
  localparam int BP_TIMEOUT  = 10;

  typedef enum {OP_WR, OP_RD, OP_EV, OP_STALL} op_e;
  typedef enum {EV_NONE, EV_FETCH, EV_LOAD, EV_LOAD_NOACK, EV_MEM_OTHER, EV_STORE,
                EV_LOAD_EXC, EV_STORE_EXC, EV_EXC, EV_STEP, EV_BRANCH} ev_e;

  typedef struct {
    op_e                      op;
    ev_e                      ev;
    logic [DBG_ADDR_SIZE-1:0] addr;
    logic [XLEN-1:0]          data;
    logic [XLEN-1:0]          exp;
    logic                     bp;
  } row_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     dbg_stall_i;
  logic                     dbg_strb_i;
  logic                     dbg_we_i;
  logic [DBG_ADDR_SIZE-1:0] dbg_addr_i;
  logic [XLEN-1:0]          dbg_d_i;
  logic [XLEN-1:0]          dbg_q_o;
  logic                     dbg_ack_o;
  logic                     dbg_bp_o;
  logic                     du_stall_o;
  logic                     du_stall_if_o;
  logic                     du_latch_nxt_pc_o;
  logic                     du_flush_o;
  logic [31:0]              du_ie_o;
  logic [XLEN-1:0]          pd_pc_i;
  logic                     if_nxt_bubble_i;
  logic                     if_bubble_i;
  opcode_e                  if_opcode_i;
  logic                     bu_flush_i;
  logic                     st_flush_i;
  logic [XLEN-1:0]          mem_memadr_i;
  opcode_e                  mem_opcode_i;
  logic                     mem_bubble_i;
  logic                     mem_exc_any_i;
  logic                     dmem_ack_i;
  logic                     ex_stall_i;
  logic [EXC_WIDTH-1:0]     du_exceptions_i;

  row_t rows[$];

  riscv_du #(.XLEN(XLEN), .BREAKPOINTS(BREAKPOINTS)) UUT (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reporting and compares
  //////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    if (got !== exp)
      fail_run($sformatf("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  //////////////////////////////
  // Table building
  //////////////////////////////
  task automatic wr_row(input logic [DBG_ADDR_SIZE-1:0] addr, input logic [XLEN-1:0] data);
    rows.push_back('{OP_WR, EV_NONE, addr, data, XLEN'(0), 1'b0});
  endtask

  task automatic rd_row(input logic [DBG_ADDR_SIZE-1:0] addr, input logic [XLEN-1:0] exp);
    rows.push_back('{OP_RD, EV_NONE, addr, XLEN'(0), exp, 1'b0});
  endtask

  task automatic ev_row(input ev_e kind, input logic [XLEN-1:0] data, input logic bp);
    rows.push_back('{OP_EV, kind, DBG_ADDR_SIZE'(0), data, XLEN'(0), bp});
  endtask

  task automatic stall_row();
    rows.push_back('{OP_STALL, EV_NONE, DBG_ADDR_SIZE'(0), XLEN'(0), XLEN'(0), 1'b0});
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////
  // Odd idle addresses never match the even breakpoint words
  task automatic drive_idle();
    pd_pc_i         = 32'h0000_0001;
    mem_memadr_i    = 32'h0000_0001;
    mem_opcode_i    = OPC_LOAD;
    mem_bubble_i    = 1'b1;
    mem_exc_any_i   = 1'b0;
    dmem_ack_i      = 1'b0;
    if_nxt_bubble_i = 1'b1;
    if_bubble_i     = 1'b1;
    if_opcode_i     = OPC_LOAD;
    du_exceptions_i = '0;
    bu_flush_i      = 1'b0;
    st_flush_i      = 1'b0;
    ex_stall_i      = 1'b0;
  endtask

  task automatic host_access(input logic we, input logic [DBG_ADDR_SIZE-1:0] addr,
                             input logic [XLEN-1:0] d, output logic [XLEN-1:0] q);
    int cycles;
    cycles     = 0;
    dbg_strb_i = 1'b1;
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_d_i    = d;
    @(negedge clk_i);
    while (!dbg_ack_o && cycles < ACK_TIMEOUT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!dbg_ack_o)
      fail_run($sformatf("Timeout: dbg_ack_o never came for address %h", addr));
    else
    begin
      q          = dbg_q_o;
      dbg_strb_i = 1'b0;
      dbg_we_i   = 1'b0;
      @(negedge clk_i);
      check_flag(dbg_ack_o, 1'b0, "dbg_ack_o one cycle after ack");
    end
  endtask

  task automatic apply_event(input ev_e kind, input logic [XLEN-1:0] value, input logic exp_bp);
    int cycles;
    cycles = 0;
    case (kind)
      EV_FETCH  : pd_pc_i = value;
      EV_EXC    : du_exceptions_i = value;
      EV_STEP   : if_nxt_bubble_i = 1'b0;
      EV_BRANCH :
      begin
        if_bubble_i = 1'b0;
        if_opcode_i = OPC_BRANCH;
      end
      default   :
      begin
        // Memory stage access
        mem_memadr_i  = value;
        mem_bubble_i  = 1'b0;
        dmem_ack_i    = (kind != EV_LOAD_NOACK);
        mem_exc_any_i = (kind == EV_LOAD_EXC || kind == EV_STORE_EXC);
        if (kind == EV_STORE || kind == EV_STORE_EXC)
          mem_opcode_i = OPC_STORE;
        else if (kind == EV_MEM_OTHER)
          mem_opcode_i = OPC_BRANCH;
        else
          mem_opcode_i = OPC_LOAD;
      end
    endcase
    @(negedge clk_i);
    drive_idle();
    if (exp_bp)
    begin
      while (!dbg_bp_o && cycles < BP_TIMEOUT)
      begin
        @(negedge clk_i);
        cycles++;
      end
      if (!dbg_bp_o)
        fail_run($sformatf("Timeout: dbg_bp_o never rose after event %s", kind.name()));
      else if (kind == EV_STEP || kind == EV_BRANCH)
        check_flag(du_stall_if_o, 1'b1, "du_stall_if_o after step or branch hit");
    end
    else
    begin
      repeat (3)
      begin
        @(negedge clk_i);
        check_flag(dbg_bp_o, 1'b0, "dbg_bp_o with no hit");
      end
    end
  endtask

  // One pulse in on entry, one flush pulse on exit
  task automatic stall_cycle();
    dbg_stall_i = 1'b1;
    #2;
    check_flag(du_stall_o, 1'b1, "du_stall_o while stalled");
    check_flag(du_stall_if_o, 1'b1, "du_stall_if_o while stalled");
    check_flag(du_latch_nxt_pc_o, 1'b1, "du_latch_nxt_pc_o on stall entry");
    repeat (2)
    begin
      @(negedge clk_i);
      check_flag(du_latch_nxt_pc_o, 1'b0, "du_latch_nxt_pc_o after entry");
      check_flag(du_flush_o, 1'b0, "du_flush_o during stall");
    end
    dbg_stall_i = 1'b0;
    #2;
    check_flag(du_stall_o, 1'b0, "du_stall_o after release");
    check_flag(du_stall_if_o, 1'b0, "du_stall_if_o after release");
    check_flag(du_flush_o, 1'b1, "du_flush_o on stall exit");
    repeat (2)
    begin
      @(negedge clk_i);
      check_flag(du_flush_o, 1'b0, "du_flush_o after exit");
    end
  endtask

  initial
  begin
    integer          seed;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] bp_word [3];
    logic [XLEN-1:0] mem_word;
    logic [XLEN-1:0] ie_word;

    rst_ni      = 1'b0;
    dbg_stall_i = 1'b0;
    dbg_strb_i  = 1'b0;
    dbg_we_i    = 1'b0;
    dbg_addr_i  = '0;
    dbg_d_i     = '0;
    drive_idle();

    seed = 32'h75b2_0cf9;
    for (int i = 0; i < 3; i++)
      bp_word[i] = $random(seed) & 32'hFFFF_FFFC;
    mem_word = $random(seed) & 32'hFFFF_FFFC;
    ie_word  = $random(seed);

    // Reset values and register access
    rd_row(DBG_CTRL, 32'h0);
    rd_row(DBG_HIT, 32'h0);
    rd_row(DBG_IE, 32'h0);
    rd_row(DBG_CAUSE, 32'h0);
    rd_row(DBG_BPCTRL0, 32'h1);
    wr_row(DBG_CTRL, 32'h0000_00FF);
    rd_row(DBG_CTRL, 32'h3);
    wr_row(DBG_CTRL, 32'h0);
    rd_row(DBG_CTRL, 32'h0);
    wr_row(DBG_IE, ie_word);
    rd_row(DBG_IE, ie_word);
    wr_row(DBG_CAUSE, 32'h8000_0007);
    rd_row(DBG_CAUSE, 32'h8000_0007);
    wr_row(DBG_HIT, 32'h0000_00F3);
    rd_row(DBG_HIT, 32'h0000_0073);
    wr_row(DBG_HIT, 32'h0);
    rd_row(DBG_HIT, 32'h0);
    wr_row(DBG_BPDATA0, bp_word[0]);
    wr_row(DBG_BPDATA1, bp_word[1]);
    wr_row(DBG_BPDATA2, bp_word[2]);
    rd_row(DBG_BPDATA0, bp_word[0]);
    rd_row(DBG_BPDATA1, bp_word[1]);
    rd_row(DBG_BPDATA2, bp_word[2]);
    wr_row(DBG_BPCTRL0, 32'h0000_0012);
    wr_row(DBG_BPCTRL1, 32'h0000_0102);
    wr_row(DBG_BPCTRL2, 32'h0000_0030);
    rd_row(DBG_BPCTRL0, 32'h0000_0013);
    rd_row(DBG_BPCTRL1, 32'h0000_0003);
    rd_row(DBG_BPCTRL2, 32'h0000_0031);
    wr_row(DBG_BPDATA3, 32'h1234_5678);
    rd_row(DBG_BPDATA3, 32'h0);
    rd_row(DBG_BPCTRL3, 32'h0);
    rd_row(8'h05, 32'h0);

    // Fetch breakpoint on BP1
    ev_row(EV_FETCH, bp_word[0], 1'b0);
    ev_row(EV_FETCH, bp_word[1], 1'b1);
    rd_row(DBG_HIT, 32'h0000_0020);
    wr_row(DBG_HIT, 32'h0);
    rd_row(DBG_HIT, 32'h0);

    // BP0 load, BP1 store, BP2 load or store, all on one address
    wr_row(DBG_BPDATA0, mem_word);
    wr_row(DBG_BPDATA1, mem_word);
    wr_row(DBG_BPDATA2, mem_word);
    wr_row(DBG_BPCTRL0, 32'h0000_0012);
    wr_row(DBG_BPCTRL1, 32'h0000_0022);
    wr_row(DBG_BPCTRL2, 32'h0000_0032);
    ev_row(EV_LOAD_NOACK, mem_word, 1'b0);
    ev_row(EV_MEM_OTHER, mem_word, 1'b0);
    rd_row(DBG_HIT, 32'h0);
    ev_row(EV_LOAD, mem_word, 1'b1);
    rd_row(DBG_HIT, 32'h0000_0050);
    wr_row(DBG_HIT, 32'h0);
    ev_row(EV_STORE, mem_word, 1'b1);
    rd_row(DBG_HIT, 32'h0000_0060);
    wr_row(DBG_HIT, 32'h0);
    ev_row(EV_LOAD_EXC, mem_word, 1'b0);
    ev_row(EV_STORE_EXC, mem_word, 1'b0);
    rd_row(DBG_HIT, 32'h0);

    // Cause capture
    ev_row(EV_EXC, 32'h0000_0040, 1'b1);
    rd_row(DBG_CAUSE, 32'h0000_0006);
    ev_row(EV_EXC, 32'h0008_0000, 1'b1);
    rd_row(DBG_CAUSE, 32'h8000_0003);
    ev_row(EV_EXC, 32'h8000_0000, 1'b1);
    rd_row(DBG_CAUSE, 32'h8000_000F);
    ev_row(EV_EXC, 32'h0004_0220, 1'b1);
    rd_row(DBG_CAUSE, 32'h0000_0005);

    // Single step and branch break
    wr_row(DBG_CTRL, 32'h1);
    ev_row(EV_STEP, 32'h0, 1'b1);
    rd_row(DBG_HIT, 32'h0000_0001);
    wr_row(DBG_CTRL, 32'h0);
    wr_row(DBG_HIT, 32'h0);
    wr_row(DBG_CTRL, 32'h2);
    ev_row(EV_BRANCH, 32'h0, 1'b1);
    rd_row(DBG_HIT, 32'h0000_0002);
    wr_row(DBG_CTRL, 32'h0);
    wr_row(DBG_HIT, 32'h0);

    // Stall entry and exit, exit flush clears CAUSE
    stall_row();
    rd_row(DBG_CAUSE, 32'h0);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_flag(dbg_ack_o, 1'b0, "dbg_ack_o after reset");
    check_flag(dbg_bp_o, 1'b0, "dbg_bp_o after reset");
    check_flag(du_flush_o, 1'b0, "du_flush_o after reset");
    check_flag(du_latch_nxt_pc_o, 1'b0, "du_latch_nxt_pc_o after reset");

    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_WR    : host_access(1'b1, rows[i].addr, rows[i].data, q);
        OP_RD    :
        begin
          host_access(1'b0, rows[i].addr, XLEN'(0), q);
          check_word(q, rows[i].exp, $sformatf("read of address %h", rows[i].addr));
        end
        OP_EV    : apply_event(rows[i].ev, rows[i].data, rows[i].bp);
        default  : stall_cycle();
      endcase
    end

    // IE was written once and drives the core directly
    check_word(du_ie_o, ie_word, "du_ie_o");

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: all.f
logic/du_regs_pkg.sv
logic/du_cpu_pkg.sv
logic/du_host_port.sv
logic/du_bp_unit.sv
logic/du_trap_capture.sv
logic/du_status.sv
logic/riscv_du.sv
sim/tb_riscv_du.sv

// File: run.sh
#!/bin/sh
# Build the debug unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_riscv_du -o tb_riscv_du || exit 1

out=$(./obj_dir/tb_riscv_du)
echo "$out"
echo "$out" | grep -q -F -x "Done: no errors" && echo "PASS" && exit 0 || echo "FAIL"
exit 1
